/* smem_cfg.svh */
/*
 * sizing for the forward recirculation queue
 * read id width, queue and occurrence FIFO depths, stored interval width
 */
`ifndef SMEM_CFG_SVH
`define SMEM_CFG_SVH

`define SMEM_READ_NUM_WIDTH 8   // read id bits
`define SMEM_QUEUE_DEPTH_LOG 9  // 512 records in flight
`define SMEM_OCC_DEPTH_LOG 6    // 64 DRAM responses

// intervals never exceed this many bits
`define SMEM_INTV_STORED 33

`endif

/* queue_status_pkg.sv */
/*
 * status codes and dispatch choices of the forward queue
 */
package queue_status_pkg;

	// record status as carried by the forward pipeline
	typedef enum logic [5:0] {
		F_INIT  = 6'd0,  // first round, no query needed
		F_RUN   = 6'd1,  // still extending
		F_BREAK = 6'd2,  // finished, no DRAM lookup
		BUBBLE  = 6'h30  // empty slot
	} status_e;

	// ==============================
	// per-cycle dispatch, in priority order
	typedef enum logic [1:0] {
		D_BREAK, // head is F_BREAK
		D_MEM,   // head + oldest occurrence response
		D_NEW,   // inject new read
		D_IDLE   // bubble
	} dispatch_e;

endpackage

/* smem_types_pkg.sv */
/*
 * data types of the forward queue
 * width typedefs plus the packed record layouts kept in the
 * read queue and the occurrence FIFO
 */
`include "smem_cfg.svh"

package smem_types_pkg;

	typedef logic [`SMEM_READ_NUM_WIDTH-1:0] read_num_t;
	typedef logic [6:0] pos_t;     // query position, size or index
	typedef logic [7:0] bp_t;      // query base from read RAM
	typedef logic [`SMEM_INTV_STORED-1:0] intv_t;
	typedef logic [13:0] info_t;   // port bits 38..32 on top, 6..0 below
	typedef logic [63:0] word64_t; // port-side interval / info
	typedef logic [31:0] cnt_a_t;
	typedef logic [63:0] cnt_b_t;

	// ==============================
	// one queued forward record
	typedef struct packed {
		pos_t      ptr_curr;
		read_num_t read_num;
		intv_t     ik_x0;
		intv_t     ik_x1;
		intv_t     ik_x2;
		info_t     ik_info;
		pos_t      forward_i;
		pos_t      min_intv;
		bp_t       query;      // base fetched at stage 3
		pos_t      backward_x;
		queue_status_pkg::status_e status;
	} fwd_rec_t;

	// one occurrence response, 384 bits
	typedef struct packed {
		cnt_a_t cnt_a0;
		cnt_a_t cnt_a1;
		cnt_a_t cnt_a2;
		cnt_a_t cnt_a3;
		cnt_b_t cnt_b0;
		cnt_b_t cnt_b1;
		cnt_b_t cnt_b2;
		cnt_b_t cnt_b3;
	} occ_rec_t;

endpackage

/* queue_port_if.sv */
/*
 * push/pop port of the read queue
 * producer fills it, store holds it, consumer drains it
 */
`timescale 1ns/1ps

interface queue_port_if;

	smem_types_pkg::fwd_rec_t entry; // record to store
	logic                     push;  // 1-cycle strobe, no back-pressure
	smem_types_pkg::fwd_rec_t head;  // oldest record
	logic                     empty;
	logic                     pop;   // 1-cycle strobe, advances head

	modport producer (
		output entry,
		output push
	);

	modport store (
		input  entry,
		input  push,
		input  pop,
		output head,
		output empty
	);

	modport consumer (
		input  head,
		input  empty,
		output pop
	);

endinterface

/* query_delay_pipe.sv */
/*
 * query wait pipe
 * requests the next query base from the read RAM, holds the record three
 * stages until the base returns, packs it and pushes it into the read queue
 */
`timescale 1ns/1ps
`include "smem_cfg.svh"

module query_delay_pipe (
	input  logic                       Clk_32UI,
	input  logic                       reset_n,
	input  logic                       stall,
	input  queue_status_pkg::status_e  status,
	input  smem_types_pkg::pos_t       ptr_curr,
	input  smem_types_pkg::read_num_t  read_num,
	input  smem_types_pkg::word64_t    ik_x0, ik_x1, ik_x2, ik_info,
	input  smem_types_pkg::pos_t       forward_i, min_intv, backward_x,
	input  smem_types_pkg::pos_t       next_query_position,
	input  smem_types_pkg::bp_t        query_bp,
	output smem_types_pkg::pos_t       query_position,
	output smem_types_pkg::read_num_t  query_read_num,
	output logic [5:0]                 query_status,
	queue_port_if.producer             q
);
	import smem_types_pkg::*;
	import queue_status_pkg::*;

	// payload of one wait stage
	typedef struct packed {
		pos_t      ptr_curr;
		read_num_t read_num;
		word64_t   ik_x0;
		word64_t   ik_x1;
		word64_t   ik_x2;
		word64_t   ik_info;
		pos_t      forward_i;
		pos_t      min_intv;
		pos_t      backward_x;
	} stage_t;

	stage_t   stage_l [3];  // L0..L2 payload
	status_e  status_l [4]; // L0..L3, L3 lines up with f_data
	fwd_rec_t f_data;       // packed record, waits one edge for push
	logic     req_ok;

	// ==============================
	// RAM request, all ones when no base is needed
	assign req_ok         = (status != BUBBLE) && (status != F_BREAK);
	assign query_position = req_ok ? next_query_position : '1;
	assign query_read_num = req_ok ? read_num : '1;
	assign query_status   = req_ok ? status : '1;

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			for (int i = 0; i < 4; i++)
				status_l[i] <= BUBBLE;
		end else if (!stall) begin
			status_l[0] <= status;
			for (int i = 1; i < 4; i++)
				status_l[i] <= status_l[i-1];
		end
	end

	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			stage_l[0] <= {ptr_curr, read_num, ik_x0, ik_x1, ik_x2, ik_info,
				forward_i, min_intv, backward_x};
			stage_l[1] <= stage_l[0];
			stage_l[2] <= stage_l[1];
			// base from RAM is valid now, truncate and pack
			f_data.ptr_curr   <= stage_l[2].ptr_curr;
			f_data.read_num   <= stage_l[2].read_num;
			f_data.ik_x0      <= stage_l[2].ik_x0[`SMEM_INTV_STORED-1:0];
			f_data.ik_x1      <= stage_l[2].ik_x1[`SMEM_INTV_STORED-1:0];
			f_data.ik_x2      <= stage_l[2].ik_x2[`SMEM_INTV_STORED-1:0];
			f_data.ik_info    <= {stage_l[2].ik_info[38:32], stage_l[2].ik_info[6:0]};
			f_data.forward_i  <= stage_l[2].forward_i;
			f_data.min_intv   <= stage_l[2].min_intv;
			f_data.query      <= query_bp;
			f_data.backward_x <= stage_l[2].backward_x;
			f_data.status     <= status_l[2];
		end
	end

	// bubbles and unknown codes are dropped here
	assign q.entry = f_data;
	assign q.push  = !stall && (status_l[3] inside {F_INIT, F_RUN, F_BREAK});

	// base must be back from RAM by the packing edge
	a_push_known: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		q.push |-> !$isunknown(q.entry))
		else $error("queue push of a record with unknown bits");

endmodule

/* read_queue.sv */
/*
 * circular read queue
 * 2^SMEM_QUEUE_DEPTH_LOG forward records, head read asynchronously
 */
`timescale 1ns/1ps
`include "smem_cfg.svh"

module read_queue (
	input logic         Clk_32UI,
	input logic         reset_n,
	input logic         stall,
	queue_port_if.store q
);
	import smem_types_pkg::*;

	localparam int DEPTH = 1 << `SMEM_QUEUE_DEPTH_LOG;

	fwd_rec_t mem [DEPTH];                       // record storage
	logic [`SMEM_QUEUE_DEPTH_LOG-1:0] wr_ptr;
	logic [`SMEM_QUEUE_DEPTH_LOG-1:0] rd_ptr;
	logic [`SMEM_QUEUE_DEPTH_LOG-1:0] wr_next;
	logic full;

	assign wr_next = wr_ptr + 1'b1;
	assign full    = (wr_next == rd_ptr); // one slot kept free

	always_ff @(posedge Clk_32UI) begin
		if (q.push && !stall)
			mem[wr_ptr] <= q.entry;
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (!stall) begin
			if (q.push)
				wr_ptr <= wr_next;
			if (q.pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// pushed record visible at head next cycle
	assign q.empty = (wr_ptr == rd_ptr);
	assign q.head  = mem[rd_ptr];

	a_no_overflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		q.push |-> !full)
		else $error("read queue overflow");

endmodule

/* occ_buffer.sv */
/*
 * occurrence FIFO
 * buffers DRAM count responses, written even while the pipe stalls
 */
`timescale 1ns/1ps
`include "smem_cfg.svh"

module occ_buffer (
	input  logic                     Clk_32UI,
	input  logic                     reset_n,
	input  logic                     dram_get,
	input  smem_types_pkg::cnt_a_t   cnt_a0, cnt_a1, cnt_a2, cnt_a3,
	input  smem_types_pkg::cnt_b_t   cnt_b0, cnt_b1, cnt_b2, cnt_b3,
	input  logic                     occ_pop,
	output smem_types_pkg::occ_rec_t occ_head,
	output logic                     occ_valid
);
	import smem_types_pkg::*;

	localparam int DEPTH = 1 << `SMEM_OCC_DEPTH_LOG;

	occ_rec_t mem [DEPTH];
	logic [`SMEM_OCC_DEPTH_LOG-1:0] wr_ptr;
	logic [`SMEM_OCC_DEPTH_LOG-1:0] rd_ptr;
	logic [`SMEM_OCC_DEPTH_LOG-1:0] wr_next;

	assign wr_next = wr_ptr + 1'b1;

	always_ff @(posedge Clk_32UI) begin
		if (dram_get)
			mem[wr_ptr] <= {cnt_a0, cnt_a1, cnt_a2, cnt_a3, cnt_b0, cnt_b1, cnt_b2, cnt_b3};
	end

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (dram_get)
				wr_ptr <= wr_next;
			if (occ_pop)
				rd_ptr <= rd_ptr + 1'b1;  // pop already carries !stall
		end
	end

	assign occ_valid = (wr_ptr != rd_ptr);
	assign occ_head  = mem[rd_ptr];

	a_no_overflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		dram_get |-> wr_next != rd_ptr)
		else $error("occurrence FIFO overflow");

	a_no_underflow: assert property (@(posedge Clk_32UI) disable iff (!reset_n)
		occ_pop |-> occ_valid)
		else $error("occurrence FIFO popped while empty");

endmodule

/* queue_ctrl.sv */
/*
 * queue dispatch control
 * picks break / memory / new read / bubble each cycle, pops the queues
 * and registers the record sent back to the forward pipeline
 */
`timescale 1ns/1ps

module queue_ctrl (
	input  logic                       Clk_32UI,
	input  logic                       reset_n,
	input  logic                       stall,
	queue_port_if.consumer             q,
	input  smem_types_pkg::occ_rec_t   occ_head,
	input  logic                       occ_valid,
	output logic                       occ_pop,
	input  logic                       load_done,
	input  logic                       new_read_valid,
	input  smem_types_pkg::read_num_t  new_read_num,
	input  smem_types_pkg::word64_t    new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info,
	input  smem_types_pkg::pos_t       new_forward_i, new_min_intv,
	output logic                       new_read,
	output queue_status_pkg::status_e  status_out,
	output smem_types_pkg::pos_t       ptr_curr_out,
	output smem_types_pkg::read_num_t  read_num_out,
	output smem_types_pkg::word64_t    ik_x0_out, ik_x1_out, ik_x2_out, ik_info_out,
	output smem_types_pkg::pos_t       forward_i_out, min_intv_out, backward_x_out,
	output smem_types_pkg::bp_t        query_out,
	output smem_types_pkg::cnt_a_t     cnt_a0_out, cnt_a1_out, cnt_a2_out, cnt_a3_out,
	output smem_types_pkg::cnt_b_t     cnt_b0_out, cnt_b1_out, cnt_b2_out, cnt_b3_out
);
	import smem_types_pkg::*;
	import queue_status_pkg::*;

	dispatch_e dispatch;
	fwd_rec_t  head_rec;
	logic      head_valid;

	// stored info bits back to their port positions
	function automatic word64_t info_expand(info_t info);
		return {25'd0, info[13:7], 25'd0, info[6:0]};
	endfunction

	assign head_rec   = q.head;
	assign head_valid = !q.empty;

	// ==============================
	// dispatch priority
	always_comb begin
		if (head_valid && head_rec.status == F_BREAK)
			dispatch = D_BREAK;      // leaves w/o memory
		else if (head_valid && occ_valid)
			dispatch = D_MEM;        // pair with oldest response
		else if (load_done && new_read_valid)
			dispatch = D_NEW;
		else
			dispatch = D_IDLE;
	end

	assign q.pop    = !stall && (dispatch == D_BREAK || dispatch == D_MEM);
	assign occ_pop  = !stall && (dispatch == D_MEM);
	assign new_read = !stall && (dispatch == D_NEW);  // strobe, no handshake

	always_ff @(posedge Clk_32UI) begin
		if (!reset_n)
			status_out <= BUBBLE;
		else if (!stall)
			case (dispatch)
				D_BREAK, D_MEM: status_out <= head_rec.status;
				D_NEW:          status_out <= F_INIT;
				default:        status_out <= BUBBLE;
			endcase
	end

	// ==============================
	// record payload
	always_ff @(posedge Clk_32UI) begin
		if (!stall) begin
			case (dispatch)
				D_BREAK, D_MEM: begin
					ptr_curr_out   <= head_rec.ptr_curr;
					read_num_out   <= head_rec.read_num;
					ik_x0_out      <= word64_t'(head_rec.ik_x0);  // zero-extend
					ik_x1_out      <= word64_t'(head_rec.ik_x1);
					ik_x2_out      <= word64_t'(head_rec.ik_x2);
					ik_info_out    <= info_expand(head_rec.ik_info);
					forward_i_out  <= head_rec.forward_i;
					min_intv_out   <= head_rec.min_intv;
					backward_x_out <= head_rec.backward_x;
					query_out      <= head_rec.query;
				end
				D_NEW: begin
					ptr_curr_out   <= '0;
					read_num_out   <= new_read_num;
					ik_x0_out      <= new_ik_x0;
					ik_x1_out      <= new_ik_x1;
					ik_x2_out      <= new_ik_x2;
					ik_info_out    <= new_ik_info;
					forward_i_out  <= new_forward_i + 1'b1;
					min_intv_out   <= new_min_intv;
					backward_x_out <= new_forward_i;
					query_out      <= '0;  // first round needs no base
				end
				default: begin
					ptr_curr_out   <= '1;
					read_num_out   <= '1;
					ik_x0_out      <= '1;
					ik_x1_out      <= '1;
					ik_x2_out      <= '1;
					ik_info_out    <= '1;
					forward_i_out  <= '1;
					min_intv_out   <= '1;
					backward_x_out <= '1;
					query_out      <= '1;
				end
			endcase
			if (dispatch == D_MEM)  // counts hold otherwise
				{cnt_a0_out, cnt_a1_out, cnt_a2_out, cnt_a3_out,
					cnt_b0_out, cnt_b1_out, cnt_b2_out, cnt_b3_out} <= occ_head;
		end
	end

endmodule

/* smem_queue_top.sv */
/*
 * forward recirculation queue, top level
 * query wait pipe, read queue, occurrence FIFO and dispatch control
 */
`timescale 1ns/1ps

module smem_queue_top (
	input  logic                       Clk_32UI,
	input  logic                       reset_n,
	input  logic                       stall,

	// DRAM occurrence responses
	input  logic                       dram_get,
	input  smem_types_pkg::cnt_a_t     cnt_a0, cnt_a1, cnt_a2, cnt_a3,
	input  smem_types_pkg::cnt_b_t     cnt_b0, cnt_b1, cnt_b2, cnt_b3,
	output smem_types_pkg::cnt_a_t     cnt_a0_out, cnt_a1_out, cnt_a2_out, cnt_a3_out,
	output smem_types_pkg::cnt_b_t     cnt_b0_out, cnt_b1_out, cnt_b2_out, cnt_b3_out,

	// forward pipeline in
	input  queue_status_pkg::status_e  status,
	input  smem_types_pkg::pos_t       ptr_curr,
	input  smem_types_pkg::read_num_t  read_num,
	input  smem_types_pkg::word64_t    ik_x0, ik_x1, ik_x2, ik_info,
	input  smem_types_pkg::pos_t       forward_i, min_intv, backward_x,
	input  smem_types_pkg::pos_t       next_query_position,

	// forward pipeline out
	output queue_status_pkg::status_e  status_out,
	output smem_types_pkg::pos_t       ptr_curr_out,
	output smem_types_pkg::read_num_t  read_num_out,
	output smem_types_pkg::word64_t    ik_x0_out, ik_x1_out, ik_x2_out, ik_info_out,
	output smem_types_pkg::pos_t       forward_i_out, min_intv_out, backward_x_out,
	output smem_types_pkg::bp_t        query_out,

	// new read fetch
	output logic                       new_read,
	input  logic                       new_read_valid,
	input  logic                       load_done,
	input  smem_types_pkg::read_num_t  new_read_num,
	input  smem_types_pkg::word64_t    new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info,
	input  smem_types_pkg::pos_t       new_forward_i, new_min_intv,

	// read RAM query, base returns three edges later
	output smem_types_pkg::pos_t       query_position,
	output smem_types_pkg::read_num_t  query_read_num,
	output logic [5:0]                 query_status,
	input  smem_types_pkg::bp_t        query_bp
);
	import smem_types_pkg::*;

	occ_rec_t occ_head;   // oldest DRAM response
	logic     occ_valid;
	logic     occ_pop;

	queue_port_if rq_if ();

	// ==============================
	// datapath around the controller
	query_delay_pipe i_query_delay_pipe (.q(rq_if), .*);

	read_queue i_read_queue (.q(rq_if), .*);

	occ_buffer i_occ_buffer (.*);  // no stall, writes always land

	queue_ctrl i_queue_ctrl (.q(rq_if), .*);

endmodule

/* tb_smem_queue.sv */
/*
 * testbench for the forward recirculation queue
 * read RAM model, reference model of each leaving record and a
 * compare process that checks every output against the expected queues
 */
`timescale 1ns/1ps
`include "smem_cfg.svh"

module tb_smem_queue;
	import smem_types_pkg::*;
	import queue_status_pkg::*;

	localparam int TIMEOUT = 2000;  // cycles per wait loop
	localparam word64_t INTV_MASK = (64'd1 << `SMEM_INTV_STORED) - 64'd1;
	localparam word64_t INFO_MASK = 64'h0000_007f_0000_007f;  // bits 38..32, 6..0

	// one record as offered by the forward pipeline
	typedef struct packed {
		status_e   status;
		pos_t      ptr_curr;
		read_num_t read_num;
		word64_t   x0, x1, x2, info;
		pos_t      forward_i, min_intv, backward_x, npos;
	} in_rec_t;

	// expected output, interval fields of rec zeroed and checked as words
	typedef struct packed {
		fwd_rec_t rec;
		word64_t  x0, x1, x2, info;
	} exp_out_t;

	logic       Clk_32UI;
	logic       reset_n;
	logic       stall;
	logic       dram_get;
	cnt_a_t     cnt_a0, cnt_a1, cnt_a2, cnt_a3;
	cnt_b_t     cnt_b0, cnt_b1, cnt_b2, cnt_b3;
	cnt_a_t     cnt_a0_out, cnt_a1_out, cnt_a2_out, cnt_a3_out;
	cnt_b_t     cnt_b0_out, cnt_b1_out, cnt_b2_out, cnt_b3_out;
	status_e    status;
	status_e    status_out;
	pos_t       ptr_curr, forward_i, min_intv, backward_x, next_query_position;
	pos_t       ptr_curr_out, forward_i_out, min_intv_out, backward_x_out;
	read_num_t  read_num, read_num_out;
	word64_t    ik_x0, ik_x1, ik_x2, ik_info;
	word64_t    ik_x0_out, ik_x1_out, ik_x2_out, ik_info_out;
	bp_t        query_out;
	bp_t        query_bp = '0;
	logic       new_read, new_read_valid, load_done;
	read_num_t  new_read_num;
	word64_t    new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info;
	pos_t       new_forward_i, new_min_intv;
	pos_t       query_position;
	read_num_t  query_read_num;
	logic [5:0] query_status;

	integer   seed = 1;
	exp_out_t exp_fwd [$];          // records in push order
	exp_out_t exp_new [$];          // injected new reads
	occ_rec_t exp_occ [$];          // DRAM responses in write order
	occ_rec_t last_occ;
	logic     have_last = 1'b0;
	logic     out_live = 1'b0;      // last edge not stalled
	logic     stall_en = 1'b0;
	bp_t      bp_pipe [3];          // RAM latency

	smem_queue_top i_smem_queue_top (.*);

	initial begin
		Clk_32UI = 1'b0;
		forever #5 Clk_32UI = ~Clk_32UI;
	end

	// ==============================
	// failure reporting
	task automatic stop_run();
		$display("test failed");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic fail_now(string msg);
		$display("ERROR: %s", msg);
		stop_run();
	endtask

	task automatic check_rec(string name, fwd_rec_t exp, fwd_rec_t act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_word(string name, word64_t exp, word64_t act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_occ(string name, occ_rec_t exp, occ_rec_t act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_status(string name, status_e exp, status_e act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	// RAM request as seen right now
	task automatic check_query(string name, pos_t p, read_num_t r, logic [5:0] s);
		if ({query_position, query_read_num, query_status} !== {p, r, s}) begin
			$display("FAILED %s: expected %h, actual %h", name, {p, r, s},
				{query_position, query_read_num, query_status});
			stop_run();
		end
	endtask

	// ==============================
	// read RAM model and reference model
	function automatic bp_t ram_base(pos_t p, read_num_t r);
		return bp_t'(r * 8'd7) ^ {1'b0, p} ^ 8'h5a;
	endfunction

	function automatic exp_out_t expect_fwd(in_rec_t r);
		exp_out_t e;
		logic     req_ok;
		req_ok = (r.status != BUBBLE) && (r.status != F_BREAK);
		e = '0;
		e.rec.ptr_curr   = r.ptr_curr;
		e.rec.read_num   = r.read_num;
		e.rec.forward_i  = r.forward_i;
		e.rec.min_intv   = r.min_intv;
		e.rec.backward_x = r.backward_x;
		e.rec.status     = r.status;
		e.rec.query      = req_ok ? ram_base(r.npos, r.read_num) : ram_base('1, '1);
		e.x0   = r.x0 & INTV_MASK;  // upper interval bits dropped
		e.x1   = r.x1 & INTV_MASK;
		e.x2   = r.x2 & INTV_MASK;
		e.info = r.info & INFO_MASK;
		return e;
	endfunction

	function automatic exp_out_t expect_new(read_num_t n, word64_t a, word64_t b,
		word64_t c, word64_t i, pos_t f, pos_t m);
		exp_out_t e;
		e = '0;
		e.rec.read_num   = n;
		e.rec.forward_i  = f + 7'd1;
		e.rec.min_intv   = m;
		e.rec.backward_x = f;
		e.rec.status     = F_INIT;  // ptr_curr and query stay zero
		e.x0   = a;
		e.x1   = b;
		e.x2   = c;
		e.info = i;
		return e;
	endfunction

	// idle slot, every field all ones
	function automatic exp_out_t expect_bubble();
		exp_out_t e;
		e = '1;
		e.rec.ik_x0   = '0;  // checked as words
		e.rec.ik_x1   = '0;
		e.rec.ik_x2   = '0;
		e.rec.ik_info = '0;
		e.rec.status  = BUBBLE;
		return e;
	endfunction

	function automatic exp_out_t current_out();
		exp_out_t g;
		g = '0;
		g.rec.ptr_curr   = ptr_curr_out;
		g.rec.read_num   = read_num_out;
		g.rec.forward_i  = forward_i_out;
		g.rec.min_intv   = min_intv_out;
		g.rec.backward_x = backward_x_out;
		g.rec.query      = query_out;
		g.rec.status     = status_out;
		g.x0   = ik_x0_out;
		g.x1   = ik_x1_out;
		g.x2   = ik_x2_out;
		g.info = ik_info_out;
		return g;
	endfunction

	function automatic occ_rec_t current_occ();
		occ_rec_t o;
		o.cnt_a0 = cnt_a0_out;
		o.cnt_a1 = cnt_a1_out;
		o.cnt_a2 = cnt_a2_out;
		o.cnt_a3 = cnt_a3_out;
		o.cnt_b0 = cnt_b0_out;
		o.cnt_b1 = cnt_b1_out;
		o.cnt_b2 = cnt_b2_out;
		o.cnt_b3 = cnt_b3_out;
		return o;
	endfunction

	// base captured with the request, shown before the third live edge
	always @(posedge Clk_32UI) begin
		if (!stall) begin
			bp_pipe[0] <= ram_base(query_position, query_read_num);
			bp_pipe[1] <= bp_pipe[0];
			bp_pipe[2] <= bp_pipe[1];
		end
	end

	always @(negedge Clk_32UI)
		query_bp <= bp_pipe[2];

	// ==============================
	// compare process
	always @(posedge Clk_32UI)
		out_live <= reset_n && !stall;

	always @(negedge Clk_32UI) begin : compare
		exp_out_t got;
		exp_out_t e;
		occ_rec_t o;
		if (out_live) begin
			got = current_out();
			o   = current_occ();
			if (status_out == BUBBLE)
				e = expect_bubble();
			else if (status_out == F_INIT) begin
				if (exp_new.size() == 0)
					fail_now("new-read output appeared with no read offered");
				else
					e = exp_new.pop_front();
			end else begin
				if (exp_fwd.size() == 0)
					fail_now("record output appeared with no record queued");
				else
					e = exp_fwd.pop_front();
			end
			check_rec("output record", e.rec, got.rec);
			check_word("ik_x0_out", e.x0, got.x0);
			check_word("ik_x1_out", e.x1, got.x1);
			check_word("ik_x2_out", e.x2, got.x2);
			check_word("ik_info_out", e.info, got.info);
			if (status_out == F_RUN) begin
				if (exp_occ.size() == 0)
					fail_now("record left with an occurrence response never sent");
				else
					check_occ("occurrence words", exp_occ.pop_front(), o);
				last_occ  = o;
				have_last = 1'b1;
			end else if (have_last)
				check_occ("counts held without memory", last_occ, o);
		end
	end

	// random stall bursts
	initial begin : stall_gen
		int hold;
		hold  = 0;
		stall = 1'b0;
		forever begin
			@(negedge Clk_32UI);
			if (!stall_en)
				stall = 1'b0;
			else if (hold > 0)
				hold = hold - 1;
			else begin
				stall = !stall;
				hold  = $unsigned($random(seed)) % 6;  // 1..6 cycles per phase
			end
		end
	end

	// ==============================
	// stimulus tasks
	task automatic make_rec(input status_e s, output in_rec_t r);
		r.status     = s;
		r.ptr_curr   = pos_t'($random(seed));
		r.read_num   = read_num_t'($random(seed));
		r.x0         = {$random(seed), $random(seed)};
		r.x1         = {$random(seed), $random(seed)};
		r.x2         = {$random(seed), $random(seed)};
		r.info       = {$random(seed), $random(seed)};
		r.forward_i  = pos_t'($random(seed));
		r.min_intv   = pos_t'($random(seed));
		r.backward_x = pos_t'($random(seed));
		r.npos       = pos_t'($random(seed));
	endtask

	// held until a live edge samples it, called at a falling edge
	task automatic send_rec(input in_rec_t r);
		int   t;
		logic taken;
		status              = r.status;
		ptr_curr            = r.ptr_curr;
		read_num            = r.read_num;
		ik_x0               = r.x0;
		ik_x1               = r.x1;
		ik_x2               = r.x2;
		ik_info             = r.info;
		forward_i           = r.forward_i;
		min_intv            = r.min_intv;
		backward_x          = r.backward_x;
		next_query_position = r.npos;
		#1;
		if (r.status == F_BREAK)
			check_query("query request, break", '1, '1, '1);
		else
			check_query("query request, run", r.npos, r.read_num, r.status);
		t     = 0;
		taken = 1'b0;
		while (!taken) begin
			@(posedge Clk_32UI);
			if (!stall)
				taken = 1'b1;
			else begin
				t = t + 1;
				if (t > TIMEOUT)
					fail_now("record never sampled, stall held too long");
			end
		end
		exp_fwd.push_back(expect_fwd(r));
		@(negedge Clk_32UI);
		status = BUBBLE;
	endtask

	task automatic send_occ();
		occ_rec_t o;
		o.cnt_a0 = $random(seed);
		o.cnt_a1 = $random(seed);
		o.cnt_a2 = $random(seed);
		o.cnt_a3 = $random(seed);
		o.cnt_b0 = {$random(seed), $random(seed)};
		o.cnt_b1 = {$random(seed), $random(seed)};
		o.cnt_b2 = {$random(seed), $random(seed)};
		o.cnt_b3 = {$random(seed), $random(seed)};
		cnt_a0   = o.cnt_a0;
		cnt_a1   = o.cnt_a1;
		cnt_a2   = o.cnt_a2;
		cnt_a3   = o.cnt_a3;
		cnt_b0   = o.cnt_b0;
		cnt_b1   = o.cnt_b1;
		cnt_b2   = o.cnt_b2;
		cnt_b3   = o.cnt_b3;
		dram_get = 1'b1;  // written even in stall
		exp_occ.push_back(o);
		@(negedge Clk_32UI);
		dram_get = 1'b0;
	endtask

	task automatic offer_new_read();
		int   t;
		logic got;
		new_read_num   = read_num_t'($random(seed));
		new_ik_x0      = {$random(seed), $random(seed)};
		new_ik_x1      = {$random(seed), $random(seed)};
		new_ik_x2      = {$random(seed), $random(seed)};
		new_ik_info    = {$random(seed), $random(seed)};
		new_forward_i  = pos_t'($random(seed));
		new_min_intv   = pos_t'($random(seed));
		new_read_valid = 1'b1;
		t   = 0;
		got = 1'b0;
		while (!got) begin
			@(posedge Clk_32UI);
			if (new_read)
				got = 1'b1;
			else begin
				t = t + 1;
				if (t > TIMEOUT)
					fail_now("new_read never pulsed for an offered read");
			end
		end
		exp_new.push_back(expect_new(new_read_num, new_ik_x0, new_ik_x1, new_ik_x2,
			new_ik_info, new_forward_i, new_min_intv));
		@(negedge Clk_32UI);
		new_read_valid = 1'b0;
	endtask

	// until at most level records are still owed
	task automatic wait_outputs(int level, string what);
		int t;
		t = 0;
		while (exp_fwd.size() > level || exp_new.size() != 0) begin
			@(negedge Clk_32UI);
			t = t + 1;
			if (t > TIMEOUT)
				fail_now({what, ": expected outputs did not arrive in time"});
		end
	endtask

	// ==============================
	// tests
	initial begin : main
		in_rec_t r;
		int      n_run;
		int      n_occ;
		reset_n             = 1'b0;
		dram_get            = 1'b0;
		{cnt_a0, cnt_a1, cnt_a2, cnt_a3} = '0;
		{cnt_b0, cnt_b1, cnt_b2, cnt_b3} = '0;
		status              = BUBBLE;
		{ptr_curr, forward_i, min_intv, backward_x, next_query_position} = '0;
		read_num            = '0;
		{ik_x0, ik_x1, ik_x2, ik_info} = '0;
		load_done           = 1'b0;
		new_read_valid      = 1'b0;
		new_read_num        = '0;
		{new_ik_x0, new_ik_x1, new_ik_x2, new_ik_info} = '0;
		new_forward_i       = '0;
		new_min_intv        = '0;
		repeat (3) @(negedge Clk_32UI);
		reset_n = 1'b1;

		// idle after reset
		repeat (8) begin
			@(posedge Clk_32UI);
			if (new_read)
				fail_now("new_read pulsed with no read offered");
		end
		@(negedge Clk_32UI);
		check_status("idle after reset", BUBBLE, status_out);
		check_query("query request, bubble", '1, '1, '1);

		// new reads injected as F_INIT
		load_done = 1'b1;
		repeat (3) offer_new_read();
		wait_outputs(0, "new reads");

		// F_RUN records paired with later DRAM responses
		for (int i = 0; i < 8; i++) begin
			make_rec(F_RUN, r);
			send_rec(r);
		end
		repeat (6) @(negedge Clk_32UI);
		repeat (8) send_occ();
		wait_outputs(0, "run records");

		// break leaves alone, next run still gets the first response
		make_rec(F_BREAK, r);
		send_rec(r);
		make_rec(F_RUN, r);
		send_rec(r);
		wait_outputs(1, "break record");
		send_occ();
		wait_outputs(0, "run after break");

		// mixed traffic under random stall
		stall_en = 1'b1;
		n_run    = 0;
		n_occ    = 0;
		for (int i = 0; i < 24; i++) begin
			make_rec(($random(seed) & 3) == 0 ? F_BREAK : F_RUN, r);
			if (r.status == F_RUN)
				n_run++;
			send_rec(r);
			if (($random(seed) & 1) && n_occ < n_run) begin
				send_occ();
				n_occ++;
			end
		end
		while (n_occ < n_run) begin
			send_occ();
			n_occ++;
		end
		wait_outputs(0, "stalled traffic");
		stall_en = 1'b0;

		repeat (4) @(negedge Clk_32UI);
		if (exp_fwd.size() == 0 && exp_new.size() == 0 && exp_occ.size() == 0) begin
			$display("test passed");
			$finish;
		end else
			fail_now("expected results left over at the end of the run");
	end

endmodule

/* compile.f */
+incdir+.
queue_status_pkg.sv
smem_types_pkg.sv
queue_port_if.sv
query_delay_pipe.sv
read_queue.sv
occ_buffer.sv
queue_ctrl.sv
smem_queue_top.sv
tb_smem_queue.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_smem_queue
FILELIST  = compile.f
LOG       = sim.log
BIN       = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./$(BIN) | tee $(LOG)
	@grep -q "test passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
